/* tests/udp_rx_testdata.txt */
// columns: tag (1 hex), sub (1 hex), value (16 hex); tags 1 setting, 2 control,
// 3 replay, 4 patch, 8 word, 9 good end, a bad end, b payload, c source
// local MAC, IP, port, multicast IP, mask, enable
100000020000000001
1100000000c0a8010a
120000000000001234
1300000000e0000100
1400000000ffffff00
150000000000000001
// unicast frame, expectations first
c00000c0a801145678
b01011121314151617
b118191a1b1c1d1e1f
800002010000000002
800045000899000000
801140004000003a00
80a8c01401a8c00000
802600341278560a01
801514131211100000
801d1c1b1a19181716
800000000000001f1e
900000000000000000
// broadcast, multicast MAC, masked multicast IP
400002ffffffffffff
310000000000000001
4000020501005e0001
310000000000000001
4300e01401a8c00000
442600341278560501
310000000000000001
220000000000000000
// foreign MAC, ethertype, version, protocol, port, IP
400002020000000002
300000000000000001
410045dd8699000000
300000000000000001
410046000899000000
300000000000000001
420640004000003a00
300000000000000001
442600351278560a01
300000000000000001
442600341278560b01
300000000000000001
310000000000000001
220000000000000000
// bad frame strobe
c00000c0a801145678
b01011121314151617
b318191a1b1c1d1e1f
320000000000000001
// disabled, then enabled again
150000000000000000
300000000000000001
150000000000000001
310000000000000001
220000000000000000
// overrun with acks held off
200000000000000001
31000000000000000c
c00000c0a801145678
b51011121314151617
300000000000000004
210000000000000000
200000000000000000
220000000000000000
310000000000000001
220000000000000000
000000000000000000

/* files.f */
logic/udp_rx_pkg.sv
logic/rx_word_if.sv
logic/rx_word_tracker.sv
logic/mac_addr_filter.sv
logic/ip_udp_filter.sv
logic/rx_frame_writer.sv
logic/sync_fifo.sv
logic/udp_rx_top.sv
tests/udp_rx_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module udp_rx_tb -f files.f -o udp_rx_sim \
  && ./obj_dir/udp_rx_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation aborted"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0

/* tests/udp_rx_tb.sv */
`timescale 1ns/100ps
module udp_rx_tb;

  // small FIFO so the overrun case needs only a dozen frames
  localparam int tb_fifo_depth = 32;
  localparam int tb_af_level   = 24;
  localparam int script_len    = 128;
  localparam int drain_limit   = 2000;

  logic        mac_clk;
  logic        mac_rst;
  logic        local_enable;
  logic [47:0] local_mac;
  logic [31:0] local_ip;
  logic [15:0] local_port;
  logic [31:0] local_mc_recv_ip;
  logic [31:0] local_mc_recv_ip_mask;
  logic [63:0] mac_rx_data;
  logic [7:0]  mac_rx_data_valid;
  logic        mac_rx_good_frame;
  logic        mac_rx_bad_frame;
  logic        phy_rx_up;
  logic        app_rx_ack;
  logic        app_rx_overrun_ack;
  logic        app_rx_valid;
  logic        app_rx_end_of_frame;
  logic [63:0] app_rx_data;
  logic        app_rx_bad_frame;
  logic        app_rx_overrun;
  logic [31:0] app_rx_source_ip;
  logic [15:0] app_rx_source_port;

  // record layout is tag, sub field, then a 64-bit value
  logic [71:0] script [script_len];
  logic [63:0] cur_frame [$];
  logic [63:0] last_frame [$];
  logic [63:0] tx_words [$];
  logic [71:0] cur_exp [$];
  logic [71:0] last_exp [$];
  int          patch_idx [$];
  logic [63:0] patch_val [$];
  logic [66:0] exp_words [$];
  logic [47:0] exp_src [$];
  logic        hold_ack;
  logic        timed_out;
  int          gap_left;
  int          error_count;
  int          check_count;

  udp_rx_top #(
    .fifo_depth        (tb_fifo_depth),
    .almost_full_level (tb_af_level)
  ) udp_rx_top_inst (
    .mac_clk               (mac_clk),
    .mac_rst               (mac_rst),
    .local_enable          (local_enable),
    .local_mac             (local_mac),
    .local_ip              (local_ip),
    .local_port            (local_port),
    .local_mc_recv_ip      (local_mc_recv_ip),
    .local_mc_recv_ip_mask (local_mc_recv_ip_mask),
    .mac_rx_data           (mac_rx_data),
    .mac_rx_data_valid     (mac_rx_data_valid),
    .mac_rx_good_frame     (mac_rx_good_frame),
    .mac_rx_bad_frame      (mac_rx_bad_frame),
    .phy_rx_up             (phy_rx_up),
    .app_rx_ack            (app_rx_ack),
    .app_rx_overrun_ack    (app_rx_overrun_ack),
    .app_rx_valid          (app_rx_valid),
    .app_rx_end_of_frame   (app_rx_end_of_frame),
    .app_rx_data           (app_rx_data),
    .app_rx_bad_frame      (app_rx_bad_frame),
    .app_rx_overrun        (app_rx_overrun),
    .app_rx_source_ip      (app_rx_source_ip),
    .app_rx_source_port    (app_rx_source_port)
  );

  always #50 mac_clk = ~mac_clk;

  task automatic check_value(input string what, input logic [63:0] actual,
                             input logic [63:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Fail at %0t: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic read_word();
    logic [66:0] expected;
    logic [47:0] src;
    if (exp_words.size() == 0) begin
      error_count++;
      $display("Unexpected payload word %h at %0t while no frame was due", app_rx_data, $time);
    end else begin
      expected = exp_words.pop_front();
      check_value("payload data", app_rx_data, expected[63:0]);
      check_value("end of frame flag", 64'(app_rx_end_of_frame), 64'(expected[64]));
      check_value("bad frame flag", 64'(app_rx_bad_frame), 64'(expected[65]));
      check_value("overrun flag", 64'(app_rx_overrun), 64'(expected[66]));
      // source fields belong to the last word of each frame
      if (expected[64]) begin
        if (exp_src.size() == 0) begin
          error_count++;
          $display("End of frame at %0t has no source entry to compare with", $time);
        end else begin
          src = exp_src.pop_front();
          check_value("source ip", 64'(app_rx_source_ip), 64'(src[47:16]));
          check_value("source port", 64'(app_rx_source_port), 64'(src[15:0]));
        end
      end
    end
  endtask

  // application side, acks with random gaps unless held off
  task automatic service_output();
    app_rx_ack = 1'b0;
    if (!mac_rst && !hold_ack && app_rx_valid === 1'b1) begin
      if (gap_left > 0) begin
        gap_left--;
      end else begin
        read_word();
        app_rx_ack = 1'b1;
        gap_left   = int'($urandom % 4);
      end
    end
  endtask

  task automatic next_cycle();
    @(posedge mac_clk);
    #1;
    service_output();
  endtask

  task automatic send_frame(input logic bad);
    foreach (tx_words[i]) begin
      mac_rx_data       = tx_words[i];
      mac_rx_data_valid = 8'hFF;
      next_cycle();
    end
    // end strobe follows the last word by one cycle
    mac_rx_data_valid = 8'h00;
    mac_rx_good_frame = !bad;
    mac_rx_bad_frame  = bad;
    next_cycle();
    mac_rx_good_frame = 1'b0;
    mac_rx_bad_frame  = 1'b0;
    next_cycle();
  endtask

  task automatic push_expect(input logic [71:0] rec);
    if (rec[71:68] == 4'hC) begin
      exp_src.push_back(rec[47:0]);
    end else begin
      exp_words.push_back({rec[66:64], rec[63:0]});
    end
  endtask

  // mode bit 0 queues the saved expectations, bit 1 ends with a bad strobe
  task automatic replay_frame(input logic [3:0] mode, input int count);
    tx_words = last_frame;
    foreach (patch_idx[i]) begin
      tx_words[patch_idx[i]] = patch_val[i];
    end
    patch_idx.delete();
    patch_val.delete();
    cur_exp.delete();
    for (int r = 0; r < count; r++) begin
      if (mode[0]) begin
        foreach (last_exp[j]) begin
          push_expect(last_exp[j]);
        end
      end
      send_frame(mode[1]);
    end
  endtask

  task automatic drain_outputs();
    int waited;
    waited = 0;
    while ((exp_words.size() != 0 || app_rx_valid) && waited < drain_limit) begin
      next_cycle();
      waited++;
    end
    if (exp_words.size() != 0 || app_rx_valid) begin
      error_count++;
      timed_out = 1'b1;
      $display("Timeout: output not drained after %0d cycles, %0d words still due",
               drain_limit, exp_words.size());
    end
  endtask

  task automatic apply_setting(input logic [3:0] sel, input logic [63:0] value);
    case (sel)
      4'h0: local_mac             = value[47:0];
      4'h1: local_ip              = value[31:0];
      4'h2: local_port            = value[15:0];
      4'h3: local_mc_recv_ip      = value[31:0];
      4'h4: local_mc_recv_ip_mask = value[31:0];
      4'h5: local_enable          = value[0];
      default: begin
        error_count++;
        $display("Unknown setting %h in the test data", sel);
      end
    endcase
  endtask

  task automatic run_record(input logic [71:0] rec);
    logic [3:0] tag;
    tag = rec[71:68];
    case (tag)
      4'h1: apply_setting(rec[67:64], rec[63:0]);
      4'h2: begin
        case (rec[67:64])
          4'h0: hold_ack = rec[0];
          4'h1: begin
            app_rx_overrun_ack = 1'b1;
            next_cycle();
            app_rx_overrun_ack = 1'b0;
          end
          4'h2: drain_outputs();
          default: begin
            error_count++;
            $display("Unknown control record %h in the test data", rec);
          end
        endcase
      end
      4'h3: replay_frame(rec[67:64], int'(rec[15:0]));
      4'h4: begin
        patch_idx.push_back(int'(rec[67:64]));
        patch_val.push_back(rec[63:0]);
      end
      4'h8: cur_frame.push_back(rec[63:0]);
      4'h9, 4'hA: begin
        tx_words = cur_frame;
        send_frame(tag == 4'hA);
        last_frame = cur_frame;
        last_exp   = cur_exp;
        cur_frame.delete();
        cur_exp.delete();
      end
      4'hB, 4'hC: begin
        push_expect(rec);
        cur_exp.push_back(rec);
      end
      default: begin
        error_count++;
        $display("Unknown record %h in the test data", rec);
      end
    endcase
  endtask

  initial begin
    int idx;
    mac_clk               = 1'b0;
    mac_rst               = 1'b1;
    local_enable          = 1'b0;
    local_mac             = '0;
    local_ip              = '0;
    local_port            = '0;
    local_mc_recv_ip      = '0;
    local_mc_recv_ip_mask = '0;
    mac_rx_data           = '0;
    mac_rx_data_valid     = '0;
    mac_rx_good_frame     = 1'b0;
    mac_rx_bad_frame      = 1'b0;
    phy_rx_up             = 1'b1;
    app_rx_ack            = 1'b0;
    app_rx_overrun_ack    = 1'b0;
    hold_ack              = 1'b0;
    timed_out             = 1'b0;
    gap_left              = 0;
    error_count           = 0;
    check_count           = 0;
    void'($urandom(38888));
    foreach (script[i]) begin
      script[i] = '0;
    end
    $readmemh("tests/udp_rx_testdata.txt", script);
    repeat (5) next_cycle();
    mac_rst = 1'b0;
    idx = 0;
    // a zero tag ends the script
    while (!timed_out && idx < script_len && script[idx][71:68] != 4'h0) begin
      run_record(script[idx]);
      idx++;
    end
    if (exp_words.size() != 0 || exp_src.size() != 0) begin
      error_count++;
      $display("%0d payload words and %0d source entries were never delivered",
               exp_words.size(), exp_src.size());
    end
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* logic/udp_rx_top.sv */
`timescale 1ns/100ps
module udp_rx_top #(
  parameter int fifo_depth        = 512,
  parameter int almost_full_level = 480
) (
  input  logic        mac_clk,
  input  logic        mac_rst,
  input  logic        local_enable,
  input  logic [47:0] local_mac,
  input  logic [31:0] local_ip,
  input  logic [15:0] local_port,
  input  logic [31:0] local_mc_recv_ip,
  input  logic [31:0] local_mc_recv_ip_mask,
  input  logic [63:0] mac_rx_data,
  input  logic [7:0]  mac_rx_data_valid,
  input  logic        mac_rx_good_frame,
  input  logic        mac_rx_bad_frame,
  input  logic        phy_rx_up,
  input  logic        app_rx_ack,
  input  logic        app_rx_overrun_ack,
  output logic        app_rx_valid,
  output logic        app_rx_end_of_frame,
  output logic [63:0] app_rx_data,
  output logic        app_rx_bad_frame,
  output logic        app_rx_overrun,
  output logic [31:0] app_rx_source_ip,
  output logic [15:0] app_rx_source_port
);

  rx_word_if rx_word_bus ();

  logic                       mac_ok;
  logic                       hdr_ok;
  udp_rx_pkg::src_info_t      src_info;
  logic                       pkt_wr_en;
  udp_rx_pkg::payload_entry_t pkt_wr_data;
  udp_rx_pkg::payload_entry_t pkt_rd_data;
  logic                       pkt_empty;
  logic                       pkt_almost_full;
  logic                       ctrl_wr_en;
  udp_rx_pkg::src_info_t      ctrl_wr_data;
  udp_rx_pkg::src_info_t      ctrl_rd_data;
  logic                       ctrl_rd_en;

  rx_word_tracker rx_word_tracker_inst (
    .mac_clk           (mac_clk),
    .mac_rst           (mac_rst),
    .mac_rx_data       (mac_rx_data),
    .mac_rx_data_valid (mac_rx_data_valid),
    .mac_rx_good_frame (mac_rx_good_frame),
    .mac_rx_bad_frame  (mac_rx_bad_frame),
    .phy_rx_up         (phy_rx_up),
    .rx                (rx_word_bus.source)
  );

  // both filters watch the same word stream
  mac_addr_filter mac_addr_filter_inst (
    .mac_clk   (mac_clk),
    .mac_rst   (mac_rst),
    .rx        (rx_word_bus.sink),
    .local_mac (local_mac),
    .mac_ok    (mac_ok)
  );

  ip_udp_filter ip_udp_filter_inst (
    .mac_clk               (mac_clk),
    .mac_rst               (mac_rst),
    .rx                    (rx_word_bus.sink),
    .local_ip              (local_ip),
    .local_port            (local_port),
    .local_mc_recv_ip      (local_mc_recv_ip),
    .local_mc_recv_ip_mask (local_mc_recv_ip_mask),
    .hdr_ok                (hdr_ok),
    .src_info              (src_info)
  );

  rx_frame_writer #(
    .fifo_depth        (fifo_depth),
    .almost_full_level (almost_full_level)
  ) rx_frame_writer_inst (
    .mac_clk            (mac_clk),
    .mac_rst            (mac_rst),
    .rx                 (rx_word_bus.sink),
    .mac_ok             (mac_ok),
    .hdr_ok             (hdr_ok),
    .src_info           (src_info),
    .local_enable       (local_enable),
    .pkt_almost_full    (pkt_almost_full),
    .app_rx_overrun_ack (app_rx_overrun_ack),
    .pkt_wr_en          (pkt_wr_en),
    .pkt_wr_data        (pkt_wr_data),
    .ctrl_wr_en         (ctrl_wr_en),
    .ctrl_wr_data       (ctrl_wr_data)
  );

  sync_fifo #(
    .width             ($bits(udp_rx_pkg::payload_entry_t)),
    .fifo_depth        (fifo_depth),
    .almost_full_level (almost_full_level)
  ) pkt_fifo_inst (
    .mac_clk     (mac_clk),
    .mac_rst     (mac_rst),
    .wr_en       (pkt_wr_en),
    .wr_data     (pkt_wr_data),
    .rd_en       (app_rx_ack),
    .rd_data     (pkt_rd_data),
    .empty       (pkt_empty),
    .almost_full (pkt_almost_full)
  );

  // never fuller than the packet FIFO, so its flags go unused
  sync_fifo #(
    .width             ($bits(udp_rx_pkg::src_info_t)),
    .fifo_depth        (fifo_depth),
    .almost_full_level (almost_full_level)
  ) ctrl_fifo_inst (
    .mac_clk     (mac_clk),
    .mac_rst     (mac_rst),
    .wr_en       (ctrl_wr_en),
    .wr_data     (ctrl_wr_data),
    .rd_en       (ctrl_rd_en),
    .rd_data     (ctrl_rd_data),
    .empty       (),
    .almost_full ()
  );

  assign app_rx_valid        = !pkt_empty;
  assign app_rx_data         = pkt_rd_data.data;
  assign app_rx_end_of_frame = pkt_rd_data.eof;
  assign app_rx_bad_frame    = pkt_rd_data.bad;
  assign app_rx_overrun      = pkt_rd_data.overrun;
  assign app_rx_source_ip    = ctrl_rd_data.ip;
  assign app_rx_source_port  = ctrl_rd_data.port;

  // source info is released with the last word of its frame
  assign ctrl_rd_en = app_rx_ack && app_rx_valid && app_rx_end_of_frame;

endmodule

/* logic/sync_fifo.sv */
`timescale 1ns/100ps
module sync_fifo #(
  parameter int width             = 67,
  parameter int fifo_depth        = 512,
  parameter int almost_full_level = 480
) (
  input  logic             mac_clk,
  input  logic             mac_rst,
  input  logic             wr_en,
  input  logic [width-1:0] wr_data,
  input  logic             rd_en,
  output logic [width-1:0] rd_data,
  output logic             empty,
  output logic             almost_full
);

  localparam int addr_w = $clog2(fifo_depth);
  localparam int cnt_w  = $clog2(fifo_depth + 1);

  logic [width-1:0]  mem [fifo_depth];
  logic [addr_w-1:0] wr_ptr;
  logic [addr_w-1:0] rd_ptr;
  logic [cnt_w-1:0]  count;
  logic              full;
  logic              do_wr;
  logic              do_rd;

  assign full        = count == cnt_w'(fifo_depth);
  assign empty       = count == '0;
  assign almost_full = count >= cnt_w'(almost_full_level);
  // writes to a full FIFO and reads from an empty one are ignored
  assign do_wr       = wr_en && !full;
  assign do_rd       = rd_en && !empty;

  // show-ahead, head entry visible without a read
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge mac_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == addr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == addr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

/* logic/rx_frame_writer.sv */
`timescale 1ns/100ps
module rx_frame_writer #(
  parameter int fifo_depth        = 512,
  parameter int almost_full_level = 480
) (
  input  logic                       mac_clk,
  input  logic                       mac_rst,
  rx_word_if.sink                    rx,
  input  logic                       mac_ok,
  input  logic                       hdr_ok,
  input  udp_rx_pkg::src_info_t      src_info,
  input  logic                       local_enable,
  input  logic                       pkt_almost_full,
  input  logic                       app_rx_overrun_ack,
  output logic                       pkt_wr_en,
  output udp_rx_pkg::payload_entry_t pkt_wr_data,
  output logic                       ctrl_wr_en,
  output udp_rx_pkg::src_info_t      ctrl_wr_data
);

  // the overrun word itself needs one free slot above the level
  if (almost_full_level >= fifo_depth) begin : g_level_check
    $error("almost_full_level must be below fifo_depth");
  end

  udp_rx_pkg::writer_state_e state;

  logic        en_sample;
  logic        frame_accept;
  logic        first_word;
  logic        held_valid;
  logic [63:0] prev_word;
  logic [63:0] held_data;
  logic        data_in;
  logic        frame_end;
  logic        write_now;

  assign data_in   = rx.word_valid && rx.pos == udp_rx_pkg::data_word;
  assign frame_end = rx.good_end || rx.bad_end;
  // held word goes out once we know whether it is the last one
  assign write_now = state == udp_rx_pkg::wr_run && frame_accept && held_valid &&
                     (data_in || frame_end);

  assign pkt_wr_en           = write_now;
  assign pkt_wr_data.data    = held_data;
  assign pkt_wr_data.eof     = frame_end || pkt_almost_full;
  assign pkt_wr_data.bad     = rx.bad_end;
  assign pkt_wr_data.overrun = pkt_almost_full;

  // source info goes along with the first payload word
  assign ctrl_wr_en   = write_now && first_word;
  assign ctrl_wr_data = src_info;

  // payload starts at byte 2 of hdr_w5, so realign across word pairs
  always_ff @(posedge mac_clk) begin
    if (rx.word_valid) begin
      prev_word <= rx.word;
    end
    if (data_in) begin
      held_data <= {prev_word[23:16], prev_word[31:24], prev_word[39:32],
                    prev_word[47:40], prev_word[55:48], prev_word[63:56],
                    rx.word[7:0], rx.word[15:8]};
    end
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      state        <= udp_rx_pkg::wr_run;
      en_sample    <= 1'b0;
      frame_accept <= 1'b0;
      first_word   <= 1'b0;
      held_valid   <= 1'b0;
    end else begin
      if (rx.frame_start) begin
        en_sample    <= local_enable;
        frame_accept <= 1'b0;
        first_word   <= 1'b1;
        held_valid   <= 1'b0;
      end
      // all verdicts are settled by the last header word
      if (rx.word_valid && rx.pos == udp_rx_pkg::hdr_w5) begin
        frame_accept <= en_sample && mac_ok && hdr_ok && state == udp_rx_pkg::wr_run;
      end
      if (data_in) begin
        held_valid <= 1'b1;
      end else if (frame_end) begin
        held_valid <= 1'b0;
      end
      if (write_now) begin
        first_word <= 1'b0;
      end
      case (state)
        udp_rx_pkg::wr_run: begin
          if (write_now && pkt_almost_full) begin
            // rest of this frame is dropped too
            state        <= udp_rx_pkg::wr_overrun;
            frame_accept <= 1'b0;
          end
        end
        udp_rx_pkg::wr_overrun: begin
          if (app_rx_overrun_ack) begin
            state <= udp_rx_pkg::wr_run;
          end
        end
        default: begin
          state <= udp_rx_pkg::wr_run;
        end
      endcase
    end
  end

endmodule

/* logic/ip_udp_filter.sv */
`timescale 1ns/100ps
module ip_udp_filter (
  input  logic                  mac_clk,
  input  logic                  mac_rst,
  rx_word_if.sink               rx,
  input  logic [31:0]           local_ip,
  input  logic [15:0]           local_port,
  input  logic [31:0]           local_mc_recv_ip,
  input  logic [31:0]           local_mc_recv_ip_mask,
  output logic                  hdr_ok,
  output udp_rx_pkg::src_info_t src_info
);

  logic [15:0] ethertype;
  logic [31:0] dest_ip;
  logic [15:0] dest_port;
  logic [15:0] dest_ip_hi;
  logic        type_ok;
  logic        proto_ok;
  logic        ip_ok;
  logic        port_ok;

  assign ethertype = {rx.word[39:32], rx.word[47:40]};
  // upper half of the destination IP came with the previous word
  assign dest_ip   = {dest_ip_hi, rx.word[7:0], rx.word[15:8]};
  assign dest_port = {rx.word[39:32], rx.word[47:40]};

  assign ip_ok = (dest_ip == local_ip) ||
                 ((dest_ip & local_mc_recv_ip_mask) ==
                  (local_mc_recv_ip & local_mc_recv_ip_mask));
  assign port_ok = dest_port == local_port;

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      hdr_ok   <= 1'b0;
      type_ok  <= 1'b0;
      proto_ok <= 1'b0;
    end else begin
      if (rx.frame_start) begin
        hdr_ok <= 1'b0;
      end
      if (rx.word_valid) begin
        case (rx.pos)
          udp_rx_pkg::hdr_w1: begin
            // IPv4 without options only
            type_ok <= ethertype == udp_rx_pkg::ethertype_ipv4 &&
                       rx.word[55:48] == udp_rx_pkg::ipv4_ver_ihl;
          end
          udp_rx_pkg::hdr_w2: begin
            proto_ok <= rx.word[63:56] == udp_rx_pkg::ip_proto_udp;
          end
          udp_rx_pkg::hdr_w4: begin
            hdr_ok <= type_ok && proto_ok && ip_ok && port_ok;
          end
          default: begin
          end
        endcase
      end
    end
  end

  always_ff @(posedge mac_clk) begin
    if (rx.word_valid && rx.pos == udp_rx_pkg::hdr_w3) begin
      src_info.ip <= {rx.word[23:16], rx.word[31:24], rx.word[39:32], rx.word[47:40]};
      dest_ip_hi  <= {rx.word[55:48], rx.word[63:56]};
    end
    if (rx.word_valid && rx.pos == udp_rx_pkg::hdr_w4) begin
      src_info.port <= {rx.word[23:16], rx.word[31:24]};
    end
  end

endmodule

/* logic/mac_addr_filter.sv */
`timescale 1ns/100ps
module mac_addr_filter (
  input  logic        mac_clk,
  input  logic        mac_rst,
  rx_word_if.sink     rx,
  input  logic [47:0] local_mac,
  output logic        mac_ok
);

  logic [47:0] dest_mac;
  logic        dest_match;

  // first byte on the wire ends up most significant
  assign dest_mac = {rx.word[7:0],   rx.word[15:8],  rx.word[23:16],
                     rx.word[31:24], rx.word[39:32], rx.word[47:40]};

  always_comb begin
    dest_match = 1'b0;
    if (dest_mac == local_mac) begin
      dest_match = 1'b1;
    end
    // broadcast
    if (dest_mac == {48{1'b1}}) begin
      dest_match = 1'b1;
    end
    // IPv4 multicast group address
    if (dest_mac[47:24] == udp_rx_pkg::mcast_mac_prefix) begin
      dest_match = 1'b1;
    end
  end

  // verdict holds until the next frame's first word
  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      mac_ok <= 1'b0;
    end else if (rx.word_valid && rx.pos == udp_rx_pkg::hdr_w0) begin
      mac_ok <= dest_match;
    end
  end

endmodule

/* logic/rx_word_tracker.sv */
`timescale 1ns/100ps
module rx_word_tracker (
  input  logic        mac_clk,
  input  logic        mac_rst,
  input  logic [63:0] mac_rx_data,
  input  logic [7:0]  mac_rx_data_valid,
  input  logic        mac_rx_good_frame,
  input  logic        mac_rx_bad_frame,
  input  logic        phy_rx_up,
  rx_word_if.source   rx
);

  logic in_valid;
  logic in_start;
  logic active;

  // only full words count as data
  assign in_valid = mac_rx_data_valid == 8'hFF;
  // first word of a frame, accepted only with the link up
  assign in_start = in_valid && !active && phy_rx_up;

  always_ff @(posedge mac_clk) begin
    rx.word <= mac_rx_data;
    if (mac_rst) begin
      rx.word_valid  <= 1'b0;
      rx.frame_start <= 1'b0;
      rx.good_end    <= 1'b0;
      rx.bad_end     <= 1'b0;
      rx.pos         <= udp_rx_pkg::hdr_w0;
      active         <= 1'b0;
    end else begin
      rx.word_valid  <= in_valid && (active || phy_rx_up);
      rx.frame_start <= in_start;
      rx.good_end    <= mac_rx_good_frame && active;
      rx.bad_end     <= mac_rx_bad_frame && active;
      if (in_start) begin
        rx.pos <= udp_rx_pkg::hdr_w0;
      end else if (in_valid && active && rx.pos != udp_rx_pkg::data_word) begin
        // saturate once the header is behind us
        rx.pos <= udp_rx_pkg::hdr_word_e'(rx.pos + 3'd1);
      end
      if (mac_rx_good_frame || mac_rx_bad_frame) begin
        active <= 1'b0;
      end else if (in_start) begin
        active <= 1'b1;
      end
    end
  end

endmodule

/* logic/rx_word_if.sv */
`timescale 1ns/100ps
interface rx_word_if;

  // registered MAC word, byte 0 in bits 7:0
  logic [63:0]           word;
  logic                  word_valid;
  udp_rx_pkg::hdr_word_e pos;
  logic                  frame_start;
  // end strobes, one cycle after the last word
  logic                  good_end;
  logic                  bad_end;

  modport source (
    output word, word_valid, pos, frame_start, good_end, bad_end
  );

  modport sink (
    input word, word_valid, pos, frame_start, good_end, bad_end
  );

endinterface

/* logic/udp_rx_pkg.sv */
package udp_rx_pkg;

  // protocol constants checked by the header filters
  localparam logic [15:0] ethertype_ipv4   = 16'h0800;
  localparam logic [7:0]  ipv4_ver_ihl     = 8'h45;
  localparam logic [7:0]  ip_proto_udp     = 8'h11;
  localparam logic [23:0] mcast_mac_prefix = 24'h01005E;

  // position of a word within the frame
  // header words first, then payload carrying words
  typedef enum logic [2:0] {
    hdr_w0    = 3'd0,
    hdr_w1    = 3'd1,
    hdr_w2    = 3'd2,
    hdr_w3    = 3'd3,
    hdr_w4    = 3'd4,
    hdr_w5    = 3'd5,
    data_word = 3'd6
  } hdr_word_e;

  typedef enum logic [0:0] {
    wr_run     = 1'b0,
    wr_overrun = 1'b1
  } writer_state_e;

  // packet FIFO entry, flags on top of the data word
  typedef struct packed {
    logic        overrun;
    logic        bad;
    logic        eof;
    logic [63:0] data;
  } payload_entry_t;

  // control FIFO entry, one per accepted frame
  typedef struct packed {
    logic [15:0] port;
    logic [31:0] ip;
  } src_info_t;

endpackage
